//--- vlog.f
design/rsPkg.sv
design/slotArbiter.sv
design/entryBank.sv
design/opRouter.sv
design/intAlu.sv
design/completeUnit.sv
design/resStation.sv
verification/rsChecker.sv
verification/tbResStation.sv

//--- run.sh
#!/bin/sh
# Build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tbResStation -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

//--- verification/tbResStation.sv
`timescale 1ns/1ps

module tbResStation;
    import rsPkg::*;

    localparam int NumInstr  = 96;
    localparam int FlushGaps = 4;

    logic      clk;
    logic      rst;
    logic      flush;
    logic      dispatchValid;
    dispatch_t dispatch;
    cdb_t      cdb;
    logic      full;
    robDone_t  robDone;
    train_t    train;

    int        seed;
    int        tbErrors;
    int        chkErrors;
    int        chkChecks;
    int        chkOutstanding;
    robTag_t   nextTag;
    word_t     tagValue [RobDepth];  // What each tag broadcasts

    resStation dut (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .cdb           (cdb),
        .full          (full),
        .robDone       (robDone),
        .train         (train)
    );

    rsChecker chk (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .cdb           (cdb),
        .robDone       (robDone),
        .train         (train),
        .errors        (chkErrors),
        .checks        (chkChecks),
        .outstanding   (chkOutstanding)
    );

    always #5 clk = ~clk;

    task automatic sendInstr(input opName_t name, input logic pend1, input logic pend2,
                             input logic sameSrcs, input logic withCdb);
        dispatch_t d;
        @(negedge clk);
        while (full || chk.live[nextTag]) @(negedge clk);
        d.name         = name;
        d.robTag       = nextTag;
        d.src1.pending = pend1;
        d.src1.tag     = robTag_t'($random(seed));
        d.src1.value   = pend1 ? '0 : $random(seed);
        d.src2.pending = pend2;
        d.src2.tag     = robTag_t'($random(seed));
        d.src2.value   = pend2 ? '0 : $random(seed);
        if (sameSrcs) d.src2 = d.src1;  // Equal operands for branch coverage
        d.imm.imm      = $random(seed);
        @(posedge clk);
        dispatchValid <= 1'b1;
        dispatch      <= d;
        if (withCdb) begin
            cdb.valid <= 1'b1;
            cdb.tag   <= d.src1.tag;
            cdb.value <= ~tagValue[d.src1.tag];  // Not what the later broadcast carries
        end
        @(posedge clk);
        dispatchValid <= 1'b0;
        cdb.valid     <= 1'b0;
        nextTag = nextTag + 1'b1;
    endtask

    task automatic broadcastAll();
        for (int t = 0; t < RobDepth; t++) begin
            @(posedge clk);
            cdb.valid <= 1'b1;
            cdb.tag   <= robTag_t'(t);
            cdb.value <= tagValue[t];
        end
        @(posedge clk);
        cdb.valid <= 1'b0;
    endtask

    task automatic waitDrain();
        @(negedge clk);
        while (chkOutstanding != 0) @(negedge clk);
        repeat (3) @(negedge clk);
    endtask

    // Watchdog
    initial begin
        repeat ((NumInstr + FlushGaps) * 20) @(posedge clk);
        $display("Timeout with %0d instructions still outstanding", chkOutstanding);
        $display("tests failed");
        $finish;
    end

    initial begin
        seed = 5680;
        tbErrors = 0;
        nextTag = '0;
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        dispatchValid = 1'b0;
        dispatch = '0;
        cdb = '0;
        for (int t = 0; t < RobDepth; t++) tagValue[t] = $random(seed);
        repeat (3) begin
            @(negedge clk);
            if (robDone.valid || train.valid || full) begin
                $display("Outputs not idle during reset at %0t", $time);
                tbErrors++;
            end
        end
        @(posedge clk);
        rst <= 1'b0;

        // Every name with ready operands
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < 34; i++) begin
                sendInstr(opName_t'(i), 1'b0, 1'b0, round == 1, 1'b0);
            end
        end
        waitDrain();

        // Pending sources, some woken on the dispatch cycle
        for (int i = 0; i < 6; i++) sendInstr(opName_t'(i * 5), 1'b1, i[0], 1'b0, 1'b0);
        sendInstr(ADD, 1'b1, 1'b0, 1'b0, 1'b1);
        sendInstr(BLT, 1'b1, 1'b0, 1'b0, 1'b1);
        broadcastAll();
        waitDrain();

        // Fill every slot
        for (int i = 0; i < NumSlots; i++) sendInstr(opName_t'(i * 4), 1'b1, 1'b1, 1'b0, 1'b0);
        @(negedge clk);
        if (!full) begin
            $display("Station not full after %0d pending dispatches", NumSlots);
            tbErrors++;
        end
        broadcastAll();
        waitDrain();
        if (full) begin
            $display("Station still full after all slots completed");
            tbErrors++;
        end

        // Flush with work pending and in flight
        for (int i = 0; i < 3; i++) sendInstr(SUB, 1'b1, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < 3; i++) sendInstr(XORI, 1'b0, 1'b0, 1'b0, 1'b0);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        broadcastAll();
        for (int i = 0; i < 6; i++) sendInstr(opName_t'(28 + i), 1'b0, 1'b0, 1'b0, 1'b0);
        waitDrain();

        $display("checks %0d, checker errors %0d, testbench errors %0d",
                 chkChecks, chkErrors, tbErrors);
        if (chkErrors == 0 && tbErrors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- verification/rsChecker.sv
`timescale 1ns/1ps

module rsChecker (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             dispatchValid,
    input  rsPkg::dispatch_t dispatch,
    input  rsPkg::cdb_t      cdb,
    input  rsPkg::robDone_t  robDone,
    input  rsPkg::train_t    train,
    output int               errors,
    output int               checks,
    output int               outstanding
);
    import rsPkg::*;

    dispatch_t pend [RobDepth];  // Indexed by ROB tag
    logic      live [RobDepth];

    // Expected result straight from the instruction semantics
    function automatic word_t refResult(input opName_t name, input word_t a, input word_t b,
                                        input word_t imm);
        case (name)
            ADD:   return a + b;
            SUB:   return a - b;
            AND:   return a & b;
            OR:    return a | b;
            XOR:   return a ^ b;
            SLL:   return a << b[4:0];
            SRL:   return a >> b[4:0];
            SRA:   return word_t'($signed(a) >>> b[4:0]);
            SLT:   return word_t'($signed(a) < $signed(b));
            SLTU:  return word_t'(a < b);
            ADDI:  return a + imm;
            ANDI:  return a & imm;
            ORI:   return a | imm;
            XORI:  return a ^ imm;
            SLLI:  return a << imm[4:0];
            SRLI:  return a >> imm[4:0];
            SRAI:  return word_t'($signed(a) >>> imm[4:0]);
            SLTI:  return word_t'($signed(a) < $signed(imm));
            SLTIU: return word_t'(a < imm);
            LW, LH, LB, LBU, LHU, SW, SH, SB, JALR: return a + imm;
            BEQ:   return word_t'(a == b);
            BNE:   return word_t'(a != b);
            BLT:   return word_t'($signed(a) < $signed(b));
            BGE:   return word_t'($signed(a) >= $signed(b));
            BLTU:  return word_t'(a < b);
            BGEU:  return word_t'(a >= b);
            default: return '0;
        endcase
    endfunction

    function automatic logic branchName(input opName_t name);
        return name inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
    endfunction

    initial begin
        errors = 0;
        checks = 0;
        outstanding = 0;
    end

    always @(posedge clk) begin
        dispatch_t e;
        word_t     exp;
        logic      expMiss;
        if (rst) begin
            for (int i = 0; i < RobDepth; i++) live[i] = 1'b0;
            outstanding = 0;
        end else begin
            if (train.valid && !robDone.valid) begin
                $display("Branch training pulse at %0t without a completion", $time);
                errors = errors + 1;
            end
            if (robDone.valid) begin
                if (!live[robDone.tag]) begin
                    $display("Unexpected completion for tag %0d at %0t", robDone.tag, $time);
                    errors = errors + 1;
                end else begin
                    e = pend[robDone.tag];
                    if (e.src1.pending || e.src2.pending) begin
                        $display("Tag %0d completed at %0t before its operands were broadcast",
                                 robDone.tag, $time);
                        errors = errors + 1;
                    end
                    exp = refResult(e.name, e.src1.value, e.src2.value, e.imm.imm);
                    checks = checks + 1;
                    if (robDone.value !== exp) begin
                        $display("[ERROR] %0t robDone.value (tag %0d %s) got %h expected %h",
                                 $time, robDone.tag, e.name.name(), robDone.value, exp);
                        errors = errors + 1;
                    end
                    if (branchName(e.name)) begin
                        expMiss = e.imm.br.predTaken ^ exp[0];
                        if (!train.valid) begin
                            $display("[ERROR] %0t train.valid got 0 expected 1", $time);
                            errors = errors + 1;
                        end else if (train.mispredict !== expMiss) begin
                            $display("[ERROR] %0t train.mispredict got %b expected %b",
                                     $time, train.mispredict, expMiss);
                            errors = errors + 1;
                        end
                    end else if (train.valid) begin
                        $display("[ERROR] %0t train.valid got 1 expected 0", $time);
                        errors = errors + 1;
                    end
                    live[robDone.tag] = 1'b0;
                    outstanding = outstanding - 1;
                end
            end
            if (flush) begin
                for (int i = 0; i < RobDepth; i++) live[i] = 1'b0;  // Everything dropped
                outstanding = 0;
            end else begin
                if (dispatchValid) begin
                    if (live[dispatch.robTag]) begin
                        $display("Tag %0d dispatched again at %0t while still outstanding",
                                 dispatch.robTag, $time);
                        errors = errors + 1;
                    end
                    pend[dispatch.robTag] = dispatch;
                    live[dispatch.robTag] = 1'b1;
                    outstanding = outstanding + 1;
                end
                // Includes the instruction dispatched on this edge
                if (cdb.valid) begin
                    for (int i = 0; i < RobDepth; i++) begin
                        if (live[i] && pend[i].src1.pending && pend[i].src1.tag == cdb.tag) begin
                            pend[i].src1.pending = 1'b0;
                            pend[i].src1.value   = cdb.value;
                        end
                        if (live[i] && pend[i].src2.pending && pend[i].src2.tag == cdb.tag) begin
                            pend[i].src2.pending = 1'b0;
                            pend[i].src2.value   = cdb.value;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- design/resStation.sv
`timescale 1ns/1ps

module resStation (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             dispatchValid,
    input  rsPkg::dispatch_t dispatch,
    input  rsPkg::cdb_t      cdb,
    output logic             full,
    output rsPkg::robDone_t  robDone,
    output rsPkg::train_t    train
);
    import rsPkg::*;

    logic      hasReady;
    slotIdx_t  readyIdx;
    logic      grant;
    dispatch_t grantEntry;
    issue_t    issue;
    exec_t     exec;
    slotIdx_t  freeSlot;
    logic      freeValid;

    entryBank bank (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .cdb           (cdb),
        .issueGrant    (grant),
        .grantIdx      (readyIdx),
        .freeSlot      (freeSlot),
        .freeValid     (freeValid),
        .full          (full),
        .grantEntry    (grantEntry),
        .hasReady      (hasReady),
        .readyIdx      (readyIdx)
    );

    opRouter router (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .hasReady (hasReady),
        .readyIdx (readyIdx),
        .entry    (grantEntry),
        .grant    (grant),
        .issue    (issue)
    );

    intAlu alu (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .issue (issue),
        .exec  (exec)
    );

    completeUnit complete (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .exec      (exec),
        .robDone   (robDone),
        .train     (train),
        .freeSlot  (freeSlot),
        .freeValid (freeValid)
    );

endmodule

//--- design/completeUnit.sv
`timescale 1ns/1ps

module completeUnit (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  rsPkg::exec_t    exec,
    output rsPkg::robDone_t robDone,
    output rsPkg::train_t   train,
    output rsPkg::slotIdx_t freeSlot,
    output logic            freeValid
);
    import rsPkg::*;

    // Slot clears on the edge that registers robDone
    assign freeValid = exec.valid;
    assign freeSlot  = exec.slot;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            robDone.valid <= 1'b0;
            train.valid   <= 1'b0;
        end else begin
            robDone.valid <= exec.valid;
            train.valid   <= exec.valid && exec.isBranch;
        end
        robDone.tag   <= exec.robTag;
        robDone.value <= exec.result;
        // Compare result in bit 0 is the actual direction
        train.mispredict <= exec.predTaken ^ exec.result[0];
    end

endmodule

//--- design/intAlu.sv
`timescale 1ns/1ps

module intAlu (
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    input  rsPkg::issue_t issue,
    output rsPkg::exec_t  exec
);
    import rsPkg::*;

    word_t      result;
    logic [4:0] shamt;

    always_comb begin
        shamt = issue.rhs[4:0];
        case (issue.op)
            Add:     result = issue.lhs + issue.rhs;
            Sub:     result = issue.lhs - issue.rhs;
            And:     result = issue.lhs & issue.rhs;
            Or:      result = issue.lhs | issue.rhs;
            Xor:     result = issue.lhs ^ issue.rhs;
            Sll:     result = issue.lhs << shamt;
            Srl:     result = issue.lhs >> shamt;
            Sra:     result = word_t'($signed(issue.lhs) >>> shamt);
            // Compares give 0 or 1
            Lt:      result = word_t'($signed(issue.lhs) < $signed(issue.rhs));
            Ltu:     result = word_t'(issue.lhs < issue.rhs);
            Eq:      result = word_t'(issue.lhs == issue.rhs);
            Ne:      result = word_t'(issue.lhs != issue.rhs);
            Ge:      result = word_t'($signed(issue.lhs) >= $signed(issue.rhs));
            Geu:     result = word_t'(issue.lhs >= issue.rhs);
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            exec.valid <= 1'b0;  // Flush drops the item in this stage
        end else begin
            exec.valid <= issue.valid;
        end
        exec.result    <= result;
        exec.slot      <= issue.slot;
        exec.robTag    <= issue.robTag;
        exec.isBranch  <= issue.isBranch;
        exec.predTaken <= issue.predTaken;
    end

endmodule

//--- design/opRouter.sv
`timescale 1ns/1ps

module opRouter (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             hasReady,
    input  rsPkg::slotIdx_t  readyIdx,
    input  rsPkg::dispatch_t entry,
    output logic             grant,
    output rsPkg::issue_t    issue
);
    import rsPkg::*;

    aluOp_t op;
    logic   useImm;
    logic   isBranch;
    logic   knownName;

    always_comb begin
        op        = Add;
        useImm    = 1'b0;
        isBranch  = 1'b0;
        knownName = 1'b1;
        case (entry.name)
            ADD:               op = Add;
            SUB:               op = Sub;
            AND:               op = And;
            OR:                op = Or;
            XOR:               op = Xor;
            SLL:               op = Sll;
            SRL:               op = Srl;
            SRA:               op = Sra;
            SLT:               op = Lt;
            SLTU:              op = Ltu;
            ADDI:              begin op = Add; useImm = 1'b1; end
            ANDI:              begin op = And; useImm = 1'b1; end
            ORI:               begin op = Or;  useImm = 1'b1; end
            XORI:              begin op = Xor; useImm = 1'b1; end
            SLLI:              begin op = Sll; useImm = 1'b1; end
            SRLI:              begin op = Srl; useImm = 1'b1; end
            SRAI:              begin op = Sra; useImm = 1'b1; end
            SLTI:              begin op = Lt;  useImm = 1'b1; end
            SLTIU:             begin op = Ltu; useImm = 1'b1; end
            // Address add for memory ops and the jump target
            LW, LH, LB, LBU, LHU, SW, SH, SB, JALR: begin
                op     = Add;
                useImm = 1'b1;
            end
            BEQ:               begin op = Eq;  isBranch = 1'b1; end
            BNE:               begin op = Ne;  isBranch = 1'b1; end
            BLT:               begin op = Lt;  isBranch = 1'b1; end
            BGE:               begin op = Ge;  isBranch = 1'b1; end
            BLTU:              begin op = Ltu; isBranch = 1'b1; end
            BGEU:              begin op = Geu; isBranch = 1'b1; end
            default:           knownName = 1'b0;
        endcase
    end

    assign grant = hasReady;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= hasReady;
        end
        issue.op        <= op;
        issue.lhs       <= entry.src1.value;
        issue.rhs       <= useImm ? entry.imm.imm : entry.src2.value;
        issue.slot      <= readyIdx;
        issue.robTag    <= entry.robTag;
        issue.isBranch  <= isBranch;
        issue.predTaken <= isBranch && entry.imm.br.predTaken;
    end

    knownNameOnIssue: assert property (@(posedge clk) disable iff (rst)
        hasReady |-> knownName)
        else $error("unknown instruction name %0d in slot %0d", entry.name, readyIdx);

endmodule

//--- design/entryBank.sv
`timescale 1ns/1ps

module entryBank (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              dispatchValid,
    input  rsPkg::dispatch_t  dispatch,
    input  rsPkg::cdb_t       cdb,
    input  logic              issueGrant,
    input  rsPkg::slotIdx_t   grantIdx,
    input  rsPkg::slotIdx_t   freeSlot,
    input  logic              freeValid,
    output logic              full,
    output rsPkg::dispatch_t  grantEntry,
    output logic              hasReady,
    output rsPkg::slotIdx_t   readyIdx
);
    import rsPkg::*;

    dispatch_t           slots [NumSlots];
    logic [NumSlots-1:0] busy;
    logic [NumSlots-1:0] issued;
    logic [NumSlots-1:0] readyVec;
    slotIdx_t            freeIdx;
    logic                hasFree;
    dispatch_t           incoming;

    // Capture a broadcast value into a waiting operand
    function automatic srcOperand_t snoop(input srcOperand_t src, input cdb_t bus);
        srcOperand_t res;
        res = src;
        if (src.pending && bus.valid && bus.tag == src.tag) begin
            res.pending = 1'b0;
            res.value   = bus.value;
        end
        return res;
    endfunction

    slotArbiter arb (
        .busy     (busy),
        .ready    (readyVec),
        .freeIdx  (freeIdx),
        .hasFree  (hasFree),
        .readyIdx (readyIdx),
        .hasReady (hasReady)
    );

    always_comb begin
        for (int i = 0; i < NumSlots; i++) begin
            readyVec[i] = busy[i] && !issued[i]
                          && !slots[i].src1.pending && !slots[i].src2.pending;
        end
    end

    // Same-cycle broadcast also lands in the instruction being written
    always_comb begin
        incoming      = dispatch;
        incoming.src1 = snoop(dispatch.src1, cdb);
        incoming.src2 = snoop(dispatch.src2, cdb);
    end

    assign full       = !hasFree;
    assign grantEntry = slots[grantIdx];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy   <= '0;
            issued <= '0;
        end else begin
            if (freeValid) begin
                busy[freeSlot]   <= 1'b0;
                issued[freeSlot] <= 1'b0;
            end
            if (issueGrant) begin
                issued[grantIdx] <= 1'b1;
            end
            if (dispatchValid && hasFree) begin
                busy[freeIdx]   <= 1'b1;
                issued[freeIdx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NumSlots; i++) begin
            slots[i].src1 <= snoop(slots[i].src1, cdb);
            slots[i].src2 <= snoop(slots[i].src2, cdb);
        end
        if (dispatchValid && hasFree) begin
            slots[freeIdx] <= incoming;  // Overrides the wakeup above
        end
    end

    noDispatchWhenFull: assert property (@(posedge clk) disable iff (rst)
        dispatchValid |-> !full)
        else $error("dispatch while full");

    // Completion may only release a slot that went out through issue
    freeOnlyInFlight: assert property (@(posedge clk) disable iff (rst)
        freeValid |-> busy[freeSlot] && issued[freeSlot])
        else $error("slot %0d freed while not in flight", freeSlot);

endmodule

//--- design/slotArbiter.sv
`timescale 1ns/1ps

module slotArbiter (
    input  logic [rsPkg::NumSlots-1:0] busy,
    input  logic [rsPkg::NumSlots-1:0] ready,
    output rsPkg::slotIdx_t            freeIdx,
    output logic                       hasFree,
    output rsPkg::slotIdx_t            readyIdx,
    output logic                       hasReady
);
    import rsPkg::*;

    // Lowest set bit wins
    function automatic slotIdx_t firstSet(input logic [NumSlots-1:0] vec);
        slotIdx_t idx;
        idx = '0;
        for (int i = NumSlots - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = slotIdx_t'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        freeIdx  = firstSet(~busy);
        hasFree  = ~&busy;
        readyIdx = firstSet(ready);  // ready already excludes issued slots
        hasReady = |ready;
    end

endmodule

//--- design/rsPkg.sv
package rsPkg;

    localparam int Xlen     = 32;
    localparam int NumSlots = 8;
    localparam int RobDepth = 16;
    localparam int SlotBits = $clog2(NumSlots);
    localparam int TagBits  = $clog2(RobDepth);

    typedef logic [Xlen-1:0]     word_t;
    typedef logic [TagBits-1:0]  robTag_t;
    typedef logic [SlotBits-1:0] slotIdx_t;

    typedef enum logic [5:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        ADDI, ANDI, ORI, XORI, SLLI, SRLI, SRAI, SLTI, SLTIU,
        LW, LH, LB, LBU, LHU, SW, SH, SB,
        JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU
    } opName_t;

    typedef enum logic [3:0] {
        Add, Sub, And, Or, Xor, Sll, Srl, Sra,
        Lt, Ltu, Eq, Ne, Ge, Geu
    } aluOp_t;

    // Branches keep the predicted direction in bit 0 of the immediate
    typedef union packed {
        word_t imm;
        struct packed {
            logic [Xlen-2:0] target;
            logic            predTaken;
        } br;
    } immWord_u;

    typedef struct packed {
        logic    pending;  // Waiting on tag
        robTag_t tag;
        word_t   value;
    } srcOperand_t;

    typedef struct packed {
        opName_t     name;
        robTag_t     robTag;
        srcOperand_t src1;
        srcOperand_t src2;
        immWord_u    imm;
    } dispatch_t;

    // Result broadcast
    typedef struct packed {
        logic    valid;
        robTag_t tag;
        word_t   value;
    } cdb_t;

    typedef struct packed {
        logic     valid;
        aluOp_t   op;
        word_t    lhs;
        word_t    rhs;
        slotIdx_t slot;
        robTag_t  robTag;
        logic     isBranch;
        logic     predTaken;
    } issue_t;

    typedef struct packed {
        logic     valid;
        word_t    result;
        slotIdx_t slot;
        robTag_t  robTag;
        logic     isBranch;
        logic     predTaken;
    } exec_t;

    typedef struct packed {
        logic    valid;
        robTag_t tag;
        word_t   value;
    } robDone_t;

    typedef struct packed {
        logic valid;
        logic mispredict;
    } train_t;

endpackage
